// File: build.f
design/sdhc_dma_pkg.sv
design/dma_request.sv
design/transfer.sv
design/data_fifo.sv
design/system_ram.sv
design/sd_host_dma.sv
tb/tb_sd_host_dma.sv

// File: Bender.yml
package:
  name: sd_host_dma

sources:
  - design/sdhc_dma_pkg.sv
  - design/dma_request.sv
  - design/transfer.sv
  - design/data_fifo.sv
  - design/system_ram.sv
  - design/sd_host_dma.sv
  - target: test
    files:
      - tb/tb_sd_host_dma.sv

// File: tb/sd_dma_vectors.txt
// columns: op dir address length data_base gap (all hex)
// op 1 write via FIFO, 2 read-back, 3 zero length, 4 start while busy; gap 1 random card gaps
// eight words each way, then a short one with trailing bytes
1 0 0000000000000000 0020 00001000 0
2 1 0000000000000000 0020 00001000 0
1 0 0000000000000040 000D 0000A000 0
2 1 0000000000000040 000C 0000A000 0
// starvation, engine started before the card pushes
1 0 0000000000000080 0030 00002000 1
2 1 0000000000000080 0030 00002000 0
// 16 words, upper address bits dropped by the memory index
1 0 FFFFFFFF000000C0 0040 00003000 1
2 1 00000000000000C0 0040 00003000 1
// zero words
3 0 0000000000000000 0000 00000000 0
3 1 0000000000000010 0003 00000000 0
// second start while busy
4 1 0000000000000000 0010 00001000 0
// index wrap at the top of memory
1 0 00000000000000F8 0010 0000B000 1
2 1 00000000000000F8 0010 0000B000 1
1 0 0000000000000100 0020 0000C000 0
2 1 0000000000000000 0020 0000C000 1

// File: tb/tb_sd_host_dma.sv
// tb_sd_host_dma
// testbench for the SD host DMA data path; runs the tests in the vector file,
// plays the card side of the FIFO and checks the words that come back

`timescale 1ns/1ns

module tb_sd_host_dma;
   import sdhc_dma_pkg::*;

   localparam int FIELDS    = 6;   // op dir addr len base gap
   localparam int MAX_TESTS = 32;

   logic                CLK, rst, start, busy, done;
   logic                card_push, card_pop, fifo_empty, fifo_full;
   xfer_dir_t           direction;
   logic [ADDR_W-1:0]   address_init;
   logic [LEN_W-1:0]    length;
   logic [DATA_W-1:0]   card_push_data, card_pop_data;
   logic [63:0]         vec [FIELDS*MAX_TESTS];
   int                  errors, test_errors, tests_passed, tests_failed;
   int                  done_count, cycles, cycle_limit, seed, first_draw;

   sd_host_dma sd_host_dma_inst (.CLK, .rst, .start, .direction, .address_init,
      .length, .busy, .done, .card_push, .card_push_data, .card_pop, .card_pop_data,
      .fifo_empty, .fifo_full);

   always #5 CLK = ~CLK;

   always @(posedge CLK) begin
      if (rst) done_count <= 0;
      else if (done) done_count <= done_count + 1;   // one count per pulse
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("** FAIL **");
         $finish;
      end
   end

   ////////////////////////////////////////
   // checks and reporting
   ////////////////////////////////////////
   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s is %0h, expected %0h", name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic expect_true(input bit ok, input string what);
      assert (ok) else begin
         $display("error: %s", what);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_test(input int idx, input string what);
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0d %s: ok", idx, what);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d check(s) failed", idx, what, test_errors);
      end
   endtask

   ////////////////////////////////////////
   // DUT and card side drivers
   ////////////////////////////////////////
   // called right after a falling edge
   task automatic pulse_start(input xfer_dir_t dir, input logic [ADDR_W-1:0] addr,
                              input logic [LEN_W-1:0] len);
      start        = 1'b1;
      direction    = dir;
      address_init = addr;
      length       = len;
      @(negedge CLK);
      start = 1'b0;
   endtask

   task automatic push_words(input int n, input logic [DATA_W-1:0] base, input bit rand_gap);
      int pushed;
      int idle;
      pushed = 0;
      idle   = 0;
      while (pushed < n) begin
         @(negedge CLK);
         card_push = 1'b0;
         expect_true(!done, $sformatf("done pulsed after %0d of %0d words pushed", pushed, n));
         if (idle > 0) begin
            idle--;
         end else if (!fifo_full) begin
            card_push      = 1'b1;
            card_push_data = base + DATA_W'(pushed);   // word k is base + k
            pushed++;
            idle = rand_gap ? int'($urandom % 4) : 0;
         end
      end
      @(negedge CLK);
      card_push = 1'b0;
   endtask

   task automatic pop_words(input int n, input logic [DATA_W-1:0] base, input bit rand_gap,
                            output bit saw_done, output bit saw_full);
      int popped;
      int idle;
      bit stuck;
      popped   = 0;
      idle     = 0;
      stuck    = 1'b0;
      saw_done = 1'b0;
      saw_full = 1'b0;
      while (popped < n && !stuck) begin
         @(negedge CLK);
         card_pop = 1'b0;
         if (fifo_full) saw_full = 1'b1;
         if (done) saw_done = 1'b1;
         // once done has pulsed, every word still owed must sit in the FIFO
         stuck = saw_done && fifo_empty;
         expect_true(!stuck, $sformatf("done with %0d words missing", n - popped));
         if (idle > 0) begin
            idle--;
         end else if (!fifo_empty) begin
            compare_value("card_pop_data", card_pop_data, base + DATA_W'(popped));
            card_pop = 1'b1;
            popped++;
            idle = rand_gap ? 2 + int'($urandom % 3) : 0;   // at most one pop in 3
         end
      end
      @(negedge CLK);
      card_pop = 1'b0;
      if (done) saw_done = 1'b1;
   endtask

   task automatic wait_for_done();
      while (!done) @(negedge CLK);
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////
   initial begin
      int                  n_tests;
      int                  words;
      int                  done_before;
      bit                  saw_done;
      bit                  saw_full;
      logic                empty_before;
      logic [63:0]         op;
      logic [63:0]         gap;
      xfer_dir_t           dir;
      logic [ADDR_W-1:0]   addr;
      logic [LEN_W-1:0]    len;
      logic [DATA_W-1:0]   base;
      string               what;

      CLK            = 1'b0;
      rst            = 1'b1;
      start          = 1'b0;
      direction      = DIR_FIFO_TO_RAM;
      address_init   = '0;
      length         = '0;
      card_push      = 1'b0;
      card_push_data = '0;
      card_pop       = 1'b0;
      errors         = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      done_count     = 0;
      cycles         = 0;
      seed           = 22692;
      first_draw     = $urandom(seed);

      for (int i = 0; i < FIELDS*MAX_TESTS; i++) vec[i] = '0;
      $readmemh("tb/sd_dma_vectors.txt", vec);
      n_tests     = 0;
      cycle_limit = 0;
      while (n_tests < MAX_TESTS && vec[n_tests*FIELDS] != 0) begin
         cycle_limit += 4 * (int'(vec[n_tests*FIELDS+3][LEN_W-1:0]) / WORD_BYTES) + 20;
         n_tests++;
      end

      repeat (2) @(negedge CLK);
      rst = 1'b0;
      @(negedge CLK);
      test_errors = 0;
      expect_true(n_tests > 0, "no vectors read from tb/sd_dma_vectors.txt");
      compare_value("busy", busy, 0);
      compare_value("done", done, 0);
      compare_value("fifo_empty", fifo_empty, 1);
      compare_value("fifo_full", fifo_full, 0);
      report_test(0, "reset state");

      for (int t = 0; t < n_tests; t++) begin
         op    = vec[t*FIELDS];
         dir   = xfer_dir_t'(vec[t*FIELDS+1][0]);
         addr  = vec[t*FIELDS+2];
         len   = vec[t*FIELDS+3][LEN_W-1:0];
         base  = vec[t*FIELDS+4][DATA_W-1:0];
         gap   = vec[t*FIELDS+5];
         words = int'(len) / WORD_BYTES;   // trailing bytes dropped
         what  = $sformatf("op %0d dir %0d addr %h words %0d", op, dir, addr, words);
         test_errors = 0;
         case (op)
            1: begin
               if (gap == 0) begin
                  push_words(words, base, 1'b0);
                  pulse_start(dir, addr, len);
               end else begin
                  pulse_start(dir, addr, len);   // engine starves first
                  push_words(words, base, 1'b1);
               end
               wait_for_done();
            end
            2: begin
               pulse_start(dir, addr, len);
               pop_words(words, base, gap != 0, saw_done, saw_full);
               expect_true(saw_done, "done did not pulse during the read-back");
               if (gap != 0 && words >= 2*FIFO_DEPTH)
                  expect_true(saw_full, "fifo_full never seen under back-pressure");
            end
            3: begin
               empty_before = fifo_empty;
               pulse_start(dir, addr, len);
               wait_for_done();
               compare_value("fifo_empty", fifo_empty, empty_before);
            end
            4: begin
               done_before = done_count;
               pulse_start(dir, addr, len);
               // zero length in the other direction finishes fast if taken
               pulse_start(xfer_dir_t'(~dir), addr + ADDR_W'(64), '0);
               fork
                  pop_words(words, base, 1'b0, saw_done, saw_full);
                  begin
                     // busy is still high in the done cycle
                     wait_for_done();
                     pulse_start(xfer_dir_t'(~dir), addr + ADDR_W'(64), '0);
                  end
               join
               repeat (4) @(negedge CLK);
               expect_true(done_count - done_before == 1,
                  $sformatf("expected one done pulse, saw %0d", done_count - done_before));
            end
            default: expect_true(1'b0, $sformatf("unknown operation %0d", op));
         endcase
         @(negedge CLK);
         compare_value("busy", busy, 0);
         compare_value("fifo_empty", fifo_empty, 1);
         report_test(t + 1, what);
      end

      $display("tests %0d, passed %0d, failed %0d, failed checks %0d",
         tests_passed + tests_failed, tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: design/sd_host_dma.sv
// sd_host_dma
// top of the SD host DMA data path; request stage, transfer engine,
// data FIFO and system memory

`timescale 1ns/1ns

module sd_host_dma (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              start,
   input  sdhc_dma_pkg::xfer_dir_t           direction,
   input  logic [sdhc_dma_pkg::ADDR_W-1:0]   address_init,
   input  logic [sdhc_dma_pkg::LEN_W-1:0]    length,
   output logic                              busy,
   output logic                              done,
   input  logic                              card_push,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   card_push_data,
   input  logic                              card_pop,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   card_pop_data,
   output logic                              fifo_empty,
   output logic                              fifo_full
);
   import sdhc_dma_pkg::*;

   // request stage to engine
   logic                req_go;
   xfer_dir_t           req_dir;
   logic [ADDR_W-1:0]   req_addr;
   logic [LEN_W-1:0]    req_words;
   // engine to fifo and memory
   logic                fifo_read, fifo_write, ram_write;
   logic [DATA_W-1:0]   fifo_rd_data, fifo_wr_data;
   logic [ADDR_W-1:0]   ram_address;
   logic [DATA_W-1:0]   data_to_ram, data_from_ram;

   ////////////////////////////////////////
   // stages
   ////////////////////////////////////////
   dma_request dma_request_inst (.CLK, .rst, .start, .direction, .address_init,
      .length, .xfer_done(done), .req_go, .req_dir, .req_addr, .req_words, .busy);

   transfer transfer_inst (.CLK, .rst, .req_go, .req_dir, .req_addr, .req_words,
      .fifo_empty, .fifo_full, .fifo_rd_data, .data_from_ram, .fifo_read,
      .fifo_write, .fifo_wr_data, .ram_write, .ram_address, .data_to_ram,
      .xfer_done(done));

   data_fifo data_fifo_inst (.CLK, .rst, .card_push, .card_push_data, .card_pop,
      .card_pop_data, .fifo_read, .fifo_rd_data, .fifo_write, .fifo_wr_data,
      .fifo_empty, .fifo_full);

   system_ram system_ram_inst (.CLK, .ram_write, .ram_address, .data_to_ram,
      .data_from_ram);

endmodule

// File: design/system_ram.sv
// system_ram
// small word memory standing in for system RAM;
// clocked write, combinational read

`timescale 1ns/1ns

module system_ram (
   input  logic                              CLK,
   input  logic                              ram_write,
   input  logic [sdhc_dma_pkg::ADDR_W-1:0]   ram_address,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   data_to_ram,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   data_from_ram
);
   import sdhc_dma_pkg::*;

   logic [DATA_W-1:0]   mem [RAM_WORDS];
   logic [RAM_AW-1:0]   word_idx;

   // byte address / 4 wrapping at RAM_WORDS
   assign word_idx = ram_address[BYTE_OFS +: RAM_AW];

   ////////////////////////////////////////
   // storage
   ////////////////////////////////////////

   // contents hold whatever was last written
   always_ff @(posedge CLK) begin
      if (ram_write) begin
         mem[word_idx] <= data_to_ram;
      end
   end

   assign data_from_ram = mem[word_idx];  // same-cycle read

endmodule

// File: design/data_fifo.sv
// data_fifo
// circular word FIFO between the card port and the DMA engine;
// head word shown combinationally on both read outputs

`timescale 1ns/1ns

module data_fifo (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              card_push,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   card_push_data,
   input  logic                              card_pop,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   card_pop_data,
   input  logic                              fifo_read,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   fifo_rd_data,
   input  logic                              fifo_write,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   fifo_wr_data,
   output logic                              fifo_empty,
   output logic                              fifo_full
);
   import sdhc_dma_pkg::*;

   logic [DATA_W-1:0]   mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]  wr_ptr;
   logic [FIFO_AW-1:0]  rd_ptr;
   logic [FIFO_AW:0]    count;
   logic                push;
   logic                pop;
   logic [DATA_W-1:0]   push_data;

   // only one side pushes and one side pops in a given direction
   assign push      = (card_push || fifo_write) && !fifo_full;
   assign pop       = (card_pop || fifo_read) && !fifo_empty;
   assign push_data = fifo_write ? fifo_wr_data : card_push_data;

   assign fifo_empty    = (count == '0);
   assign fifo_full     = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign card_pop_data = mem[rd_ptr];
   assign fifo_rd_data  = mem[rd_ptr];

   always_ff @(posedge CLK) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap on their own
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (push) mem[wr_ptr] <= push_data;
   end

endmodule

// File: design/transfer.sv
// transfer
// DMA engine FSM; moves one word per clock between the data FIFO
// and system memory, stalls on FIFO empty/full, pulses xfer_done at the end

`timescale 1ns/1ns

module transfer (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              req_go,
   input  sdhc_dma_pkg::xfer_dir_t           req_dir,
   input  logic [sdhc_dma_pkg::ADDR_W-1:0]   req_addr,
   input  logic [sdhc_dma_pkg::LEN_W-1:0]    req_words,
   input  logic                              fifo_empty,
   input  logic                              fifo_full,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   fifo_rd_data,
   input  logic [sdhc_dma_pkg::DATA_W-1:0]   data_from_ram,
   output logic                              fifo_read,
   output logic                              fifo_write,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   fifo_wr_data,
   output logic                              ram_write,
   output logic [sdhc_dma_pkg::ADDR_W-1:0]   ram_address,
   output logic [sdhc_dma_pkg::DATA_W-1:0]   data_to_ram,
   output logic                              xfer_done
);
   import sdhc_dma_pkg::*;

   xfer_state_t         state;
   xfer_state_t         state_n;
   logic [ADDR_W-1:0]   addr_q;      // running byte address
   logic [LEN_W-1:0]    words_left;
   logic                load;        // request taken in idle
   logic                move;        // a word moves this cycle
   logic                last;

   assign load = (state == S_IDLE) && req_go;
   assign last = (words_left == LEN_W'(1));

   ////////////////////////////////////////
   // next state and strobes
   ////////////////////////////////////////
   always_comb begin
      state_n    = state;
      move       = 1'b0;
      fifo_read  = 1'b0;
      fifo_write = 1'b0;
      ram_write  = 1'b0;
      case (state)
         S_IDLE: begin
            if (req_go) begin
               if (req_words == '0) begin
                  state_n = S_DONE;       // nothing to move
               end else if (req_dir == DIR_FIFO_TO_RAM) begin
                  state_n = S_FIFO_RAM;
               end else begin
                  state_n = S_RAM_FIFO;
               end
            end
         end
         // pop the head word into memory
         S_FIFO_RAM, S_WAIT_READ: begin
            if (!fifo_empty) begin
               fifo_read = 1'b1;
               ram_write = 1'b1;
               move      = 1'b1;
               state_n   = last ? S_DONE : S_FIFO_RAM;
            end else begin
               state_n = S_WAIT_READ;
            end
         end
         // push the addressed memory word into the FIFO
         S_RAM_FIFO, S_WAIT_WRITE: begin
            if (!fifo_full) begin
               fifo_write = 1'b1;
               move       = 1'b1;
               state_n    = last ? S_DONE : S_RAM_FIFO;
            end else begin
               state_n = S_WAIT_WRITE;
            end
         end
         S_DONE:  state_n = S_IDLE;
         default: state_n = S_IDLE;
      endcase
   end

   // data paths straight across and qualified by the strobes
   assign ram_address  = addr_q;
   assign data_to_ram  = fifo_rd_data;
   assign fifo_wr_data = data_from_ram;
   assign xfer_done    = (state == S_DONE);

   ////////////////////////////////////////
   // state and counters
   ////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         state      <= S_IDLE;
         words_left <= '0;
      end else begin
         state <= state_n;
         if (load) begin
            words_left <= req_words;
         end else if (move) begin
            words_left <= words_left - LEN_W'(1);
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (load) begin
         addr_q <= req_addr;
      end else if (move) begin
         addr_q <= addr_q + ADDR_W'(WORD_BYTES);   // next word
      end
   end

endmodule

// File: design/dma_request.sv
// dma_request
// request stage of the DMA path; takes a start strobe while idle,
// holds direction, address and word count, and issues req_go to the engine

`timescale 1ns/1ns

module dma_request (
   input  logic                              CLK,
   input  logic                              rst,
   input  logic                              start,
   input  sdhc_dma_pkg::xfer_dir_t           direction,
   input  logic [sdhc_dma_pkg::ADDR_W-1:0]   address_init,
   input  logic [sdhc_dma_pkg::LEN_W-1:0]    length,
   input  logic                              xfer_done,
   output logic                              req_go,
   output sdhc_dma_pkg::xfer_dir_t           req_dir,
   output logic [sdhc_dma_pkg::ADDR_W-1:0]   req_addr,
   output logic [sdhc_dma_pkg::LEN_W-1:0]    req_words,
   output logic                              busy
);
   import sdhc_dma_pkg::*;

   logic accept;

   assign accept = start && !busy;  // start while busy is dropped

   // busy and go pulse
   always_ff @(posedge CLK) begin
      if (rst) begin
         req_go <= 1'b0;
         busy   <= 1'b0;
      end else begin
         req_go <= accept;
         if (accept) begin
            busy <= 1'b1;
         end else if (xfer_done) begin
            busy <= 1'b0;   // falls the cycle after done
         end
      end
   end

   // request values held steady for the whole transfer
   always_ff @(posedge CLK) begin
      if (accept) begin
         req_dir   <= direction;
         req_addr  <= address_init;
         // trailing bytes are dropped
         req_words <= length / LEN_W'(WORD_BYTES);
      end
   end

endmodule

// File: design/sdhc_dma_pkg.sv
// sdhc_dma_pkg
// widths, depths and enums shared by the SD host DMA data path

package sdhc_dma_pkg;

   ////////////////////////////////////////
   // widths and depths
   ////////////////////////////////////////
   localparam int ADDR_W     = 64;  // byte address
   localparam int DATA_W     = 32;  // data word
   localparam int LEN_W      = 16;  // byte length of a request
   localparam int WORD_BYTES = 4;
   localparam int BYTE_OFS   = $clog2(WORD_BYTES);  // byte lane bits in an address

   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   localparam int RAM_WORDS  = 64;
   localparam int RAM_AW     = $clog2(RAM_WORDS);

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////
   typedef enum logic [0:0] {
      DIR_FIFO_TO_RAM = 1'b0,
      DIR_RAM_TO_FIFO = 1'b1
   } xfer_dir_t;

   typedef enum logic [2:0] {
      S_IDLE, S_FIFO_RAM, S_RAM_FIFO, S_WAIT_READ, S_WAIT_WRITE, S_DONE
   } xfer_state_t;

endpackage
